/* Makefile */
TOP = tb_rv_core

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sources.f --Mdir obj_dir -o sim_$(TOP)
	@out=$$(./obj_dir/sim_$(TOP)); echo "$$out"; echo "$$out" | grep -q "No errors"

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* rtl/rv_core_pkg.sv */
package rv_core_pkg;

  // one instruction walks through these in order
  typedef enum logic [2:0] {
    st_fetch,
    st_execute,
    st_memory,      // loads and stores only
    st_writeback,
    st_halted       // left only through reset
  } stage_e;

  typedef enum logic [1:0] {
    ph_idle,
    ph_setup,
    ph_access
  } apb_phase_e;

  // first operand of the shared adder
  typedef enum logic [1:0] {
    op_a_rs1,
    op_a_pc,
    op_a_zero
  } op_a_sel_e;

  // source of the register write
  typedef enum logic [1:0] {
    wb_result,      // adder output
    wb_link,        // pc + 4
    wb_load
  } wb_sel_e;

endpackage

/* rtl/rv_core_top.sv */
`timescale 1ns/100ps

module rv_core_top #(
  parameter rv_isa_pkg::word_t RESET_PC = 32'h8000_0000
) (
  input  logic              clk,
  input  logic              reset,
  output rv_isa_pkg::word_t pc,
  input  rv_isa_pkg::word_t inst,
  output rv_isa_pkg::word_t paddr,
  output logic              psel,
  output logic              penable,
  output logic              pwrite,
  output rv_isa_pkg::word_t pwdata,
  output rv_isa_pkg::strb_t pstrb,
  input  rv_isa_pkg::word_t prdata,
  input  logic              pready,
  output logic              halt
);

  rv_isa_pkg::word_t       inst_q;
  rv_isa_pkg::word_t       imm;
  rv_isa_pkg::word_t       rs1_data;
  rv_isa_pkg::word_t       rs2_data;
  rv_isa_pkg::word_t       result;
  rv_isa_pkg::word_t       link;
  rv_isa_pkg::word_t       next_pc;
  rv_isa_pkg::word_t       store_data;
  rv_isa_pkg::word_t       load_data;
  rv_isa_pkg::reg_addr_t   rs1;
  rv_isa_pkg::reg_addr_t   rs2;
  rv_isa_pkg::reg_addr_t   rd;
  rv_isa_pkg::mem_funct3_e funct3;
  rv_core_pkg::op_a_sel_e  op_a_sel;
  rv_core_pkg::wb_sel_e    wb_sel;
  logic                    ex_en;
  logic                    mem_start;
  logic                    mem_done;
  logic                    wb_en;
  logic                    reg_write;
  logic                    mem_op;
  logic                    mem_write;
  logic                    jump;
  logic                    stop;

  rv_sequencer #(.RESET_PC(RESET_PC)) u_sequencer (
    .clk, .reset, .mem_op, .stop, .mem_done, .next_pc, .inst,
    .pc, .inst_q, .ex_en, .mem_start, .wb_en, .halt
  );

  rv_decode u_decode (
    .inst_q, .rs1, .rs2, .rd, .imm, .op_a_sel, .wb_sel,
    .reg_write, .mem_op, .mem_write, .jump, .stop, .funct3
  );

  rv_execute u_execute (
    .clk, .reset, .ex_en, .pc, .rs1_data, .rs2_data, .imm, .op_a_sel, .jump,
    .result, .link, .next_pc, .store_data
  );

  // load/store address is the latched adder result
  rv_lsu_apb u_lsu (
    .clk, .reset, .mem_start, .mem_write, .funct3, .addr(result), .store_data,
    .load_data, .mem_done, .paddr, .pwdata, .psel, .penable, .pwrite, .pstrb,
    .prdata, .pready
  );

  rv_regfile_wb u_regfile (
    .clk, .wb_en, .reg_write, .rd, .rs1, .rs2, .wb_sel, .result, .link,
    .load_data, .rs1_data, .rs2_data
  );

endmodule

/* rtl/rv_decode.sv */
`timescale 1ns/100ps

module rv_decode (
  input  rv_isa_pkg::word_t         inst_q,
  output rv_isa_pkg::reg_addr_t     rs1,
  output rv_isa_pkg::reg_addr_t     rs2,
  output rv_isa_pkg::reg_addr_t     rd,
  output rv_isa_pkg::word_t         imm,
  output rv_core_pkg::op_a_sel_e    op_a_sel,
  output rv_core_pkg::wb_sel_e      wb_sel,
  output logic                      reg_write,
  output logic                      mem_op,
  output logic                      mem_write,
  output logic                      jump,
  output logic                      stop,
  output rv_isa_pkg::mem_funct3_e   funct3
);

  rv_isa_pkg::word_t imm_i;
  rv_isa_pkg::word_t imm_s;
  rv_isa_pkg::word_t imm_u;
  rv_isa_pkg::word_t imm_j;
  logic [2:0]        f3;
  logic              writes_rd;

  assign rs1    = inst_q[19:15];
  assign rs2    = inst_q[24:20];
  assign rd     = inst_q[11:7];
  assign f3     = inst_q[14:12];
  assign funct3 = rv_isa_pkg::mem_funct3_e'(f3);

  assign imm_i = {{20{inst_q[31]}}, inst_q[31:20]};
  assign imm_s = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
  assign imm_u = {inst_q[31:12], 12'h000};                        // already shifted
  assign imm_j = {{12{inst_q[31]}}, inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};

  always_comb begin
    imm       = imm_i;
    op_a_sel  = rv_core_pkg::op_a_rs1;
    wb_sel    = rv_core_pkg::wb_result;
    writes_rd = 1'b0;
    mem_op    = 1'b0;
    mem_write = 1'b0;
    jump      = 1'b0;
    stop      = 1'b0;
    case (rv_isa_pkg::opcode_e'(inst_q[6:0]))
      rv_isa_pkg::opc_op_imm: begin
        writes_rd = (f3 == rv_isa_pkg::funct3_addi);
        stop      = (f3 != rv_isa_pkg::funct3_addi);   // only addi is kept
      end
      rv_isa_pkg::opc_lui: begin
        imm       = imm_u;
        op_a_sel  = rv_core_pkg::op_a_zero;
        writes_rd = 1'b1;
      end
      rv_isa_pkg::opc_auipc: begin
        imm       = imm_u;
        op_a_sel  = rv_core_pkg::op_a_pc;
        writes_rd = 1'b1;
      end
      rv_isa_pkg::opc_jal: begin
        imm       = imm_j;
        op_a_sel  = rv_core_pkg::op_a_pc;
        wb_sel    = rv_core_pkg::wb_link;
        writes_rd = 1'b1;
        jump      = 1'b1;
      end
      rv_isa_pkg::opc_jalr: begin
        wb_sel    = rv_core_pkg::wb_link;
        writes_rd = (f3 == rv_isa_pkg::funct3_addi);
        jump      = 1'b1;
        stop      = (f3 != rv_isa_pkg::funct3_addi);
      end
      rv_isa_pkg::opc_load: begin
        wb_sel    = rv_core_pkg::wb_load;
        writes_rd = 1'b1;
        mem_op    = 1'b1;
        stop      = !(f3 inside {rv_isa_pkg::f3_byte, rv_isa_pkg::f3_half,
                                 rv_isa_pkg::f3_word, rv_isa_pkg::f3_byte_u,
                                 rv_isa_pkg::f3_half_u});
      end
      rv_isa_pkg::opc_store: begin
        imm       = imm_s;
        mem_op    = 1'b1;
        mem_write = 1'b1;
        stop      = (f3 > rv_isa_pkg::f3_word);      // sb, sh, sw only
      end
      default: stop = 1'b1;                            // system and anything unknown
    endcase
  end

  // x0 is never written, nor by a stopping instruction
  assign reg_write = writes_rd && !stop && (rd != 5'd0);

endmodule

/* rtl/rv_execute.sv */
`timescale 1ns/100ps

module rv_execute (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   ex_en,
  input  rv_isa_pkg::word_t      pc,
  input  rv_isa_pkg::word_t      rs1_data,
  input  rv_isa_pkg::word_t      rs2_data,
  input  rv_isa_pkg::word_t      imm,
  input  rv_core_pkg::op_a_sel_e op_a_sel,
  input  logic                   jump,
  output rv_isa_pkg::word_t      result,
  output rv_isa_pkg::word_t      link,
  output rv_isa_pkg::word_t      next_pc,
  output rv_isa_pkg::word_t      store_data
);

  rv_isa_pkg::word_t op_a;
  rv_isa_pkg::word_t sum;
  rv_isa_pkg::word_t pc_plus4;

  always_comb begin
    case (op_a_sel)
      rv_core_pkg::op_a_rs1: op_a = rs1_data;
      rv_core_pkg::op_a_pc:  op_a = pc;
      default:               op_a = '0;     // lui
    endcase
  end

  assign sum      = op_a + imm;             // the one adder
  assign pc_plus4 = pc + 32'd4;

  always_ff @(posedge clk) begin
    if (reset) begin
      result  <= '0;
      next_pc <= '0;
    end else if (ex_en) begin
      result  <= sum;
      next_pc <= jump ? {sum[31:1], 1'b0} : pc_plus4;   // jalr drops bit 0
    end
  end

  always_ff @(posedge clk) begin
    if (ex_en) begin
      link       <= pc_plus4;
      store_data <= rs2_data;
    end
  end

endmodule

/* rtl/rv_isa_pkg.sv */
package rv_isa_pkg;

  typedef logic [31:0] word_t;      // data, address and instruction word
  typedef logic [4:0]  reg_addr_t;
  typedef logic [3:0]  strb_t;      // one bit per byte lane

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    opc_load   = 7'b000_0011,
    opc_op_imm = 7'b001_0011,
    opc_auipc  = 7'b001_0111,
    opc_store  = 7'b010_0011,
    opc_lui    = 7'b011_0111,
    opc_jalr   = 7'b110_0111,
    opc_jal    = 7'b110_1111,
    opc_system = 7'b111_0011
  } opcode_e;

  // width field of loads and stores, inst[14:12]
  typedef enum logic [2:0] {
    f3_byte   = 3'b000,
    f3_half   = 3'b001,
    f3_word   = 3'b010,
    f3_byte_u = 3'b100,
    f3_half_u = 3'b101
  } mem_funct3_e;

  // addi and jalr both use funct3 000
  localparam logic [2:0] funct3_addi = 3'b000;

endpackage

/* rtl/rv_lsu_apb.sv */
`timescale 1ns/100ps

module rv_lsu_apb (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    mem_start,
  input  logic                    mem_write,
  input  rv_isa_pkg::mem_funct3_e funct3,
  input  rv_isa_pkg::word_t       addr,
  input  rv_isa_pkg::word_t       store_data,
  output rv_isa_pkg::word_t       load_data,
  output logic                    mem_done,
  output rv_isa_pkg::word_t       paddr,
  output rv_isa_pkg::word_t       pwdata,
  output logic                    psel,
  output logic                    penable,
  output logic                    pwrite,
  output rv_isa_pkg::strb_t       pstrb,
  input  rv_isa_pkg::word_t       prdata,
  input  logic                    pready
);

  rv_core_pkg::apb_phase_e phase_q;
  rv_core_pkg::apb_phase_e phase;
  rv_isa_pkg::strb_t       strb_base;
  rv_isa_pkg::word_t       rd_shift;
  rv_isa_pkg::word_t       rd_ext;
  logic [1:0]              offset;

  assign offset = addr[1:0];

  // setup is the mem_start cycle itself so memory takes two cycles plus waits
  always_comb begin
    phase = phase_q;
    if (phase_q == rv_core_pkg::ph_idle && mem_start) phase = rv_core_pkg::ph_setup;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      phase_q <= rv_core_pkg::ph_idle;
    end else begin
      case (phase)
        rv_core_pkg::ph_setup:  phase_q <= rv_core_pkg::ph_access;
        rv_core_pkg::ph_access: if (pready) phase_q <= rv_core_pkg::ph_idle;
        default:                phase_q <= rv_core_pkg::ph_idle;
      endcase
    end
  end

  assign psel     = (phase != rv_core_pkg::ph_idle);
  assign penable  = (phase == rv_core_pkg::ph_access);
  assign mem_done = penable && pready;

  // address, data and strobe come from registers held through memory
  assign paddr  = {addr[31:2], 2'b00};
  assign pwrite = mem_write;
  assign pwdata = store_data << {offset, 3'b000};

  always_comb begin
    case (funct3)
      rv_isa_pkg::f3_byte: strb_base = 4'b0001;
      rv_isa_pkg::f3_half: strb_base = 4'b0011;
      default:             strb_base = 4'b1111;
    endcase
  end

  assign pstrb = mem_write ? rv_isa_pkg::strb_t'(strb_base << offset) : 4'b0000;  // no strobes on reads

  // pick the lane and extend
  assign rd_shift = prdata >> {offset, 3'b000};

  always_comb begin
    case (funct3)
      rv_isa_pkg::f3_byte:   rd_ext = {{24{rd_shift[7]}}, rd_shift[7:0]};
      rv_isa_pkg::f3_half:   rd_ext = {{16{rd_shift[15]}}, rd_shift[15:0]};
      rv_isa_pkg::f3_byte_u: rd_ext = {24'h000000, rd_shift[7:0]};
      rv_isa_pkg::f3_half_u: rd_ext = {16'h0000, rd_shift[15:0]};
      default:               rd_ext = prdata;     // lw
    endcase
  end

  always_ff @(posedge clk) begin
    if (mem_done) load_data <= rd_ext;
  end

  // access always follows a setup cycle
  assert property (@(posedge clk) disable iff (reset) penable |-> psel && $past(psel));

  // address held from setup through the last wait cycle
  assert property (@(posedge clk) disable iff (reset) penable |-> $stable(paddr));

  assert property (@(posedge clk) disable iff (reset)
    psel && (funct3 inside {rv_isa_pkg::f3_half, rv_isa_pkg::f3_half_u}) |-> !addr[0]);

  assert property (@(posedge clk) disable iff (reset)
    psel && (funct3 == rv_isa_pkg::f3_word) |-> offset == 2'b00);

endmodule

/* rtl/rv_regfile_wb.sv */
`timescale 1ns/100ps

module rv_regfile_wb (
  input  logic                  clk,
  input  logic                  wb_en,
  input  logic                  reg_write,
  input  rv_isa_pkg::reg_addr_t rd,
  input  rv_isa_pkg::reg_addr_t rs1,
  input  rv_isa_pkg::reg_addr_t rs2,
  input  rv_core_pkg::wb_sel_e  wb_sel,
  input  rv_isa_pkg::word_t     result,
  input  rv_isa_pkg::word_t     link,
  input  rv_isa_pkg::word_t     load_data,
  output rv_isa_pkg::word_t     rs1_data,
  output rv_isa_pkg::word_t     rs2_data
);

  rv_isa_pkg::word_t regs [32];
  rv_isa_pkg::word_t wb_value;

  always_comb begin
    case (wb_sel)
      rv_core_pkg::wb_link: wb_value = link;
      rv_core_pkg::wb_load: wb_value = load_data;
      default:              wb_value = result;
    endcase
  end

  always_ff @(posedge clk) begin
    if (wb_en && reg_write) regs[rd] <= wb_value;    // rd is never 0 here
  end

  // x0 reads as zero
  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

/* rtl/rv_sequencer.sv */
`timescale 1ns/100ps

module rv_sequencer #(
  parameter rv_isa_pkg::word_t RESET_PC = 32'h8000_0000
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              mem_op,
  input  logic              stop,
  input  logic              mem_done,
  input  rv_isa_pkg::word_t next_pc,
  input  rv_isa_pkg::word_t inst,
  output rv_isa_pkg::word_t pc,
  output rv_isa_pkg::word_t inst_q,
  output logic              ex_en,
  output logic              mem_start,
  output logic              wb_en,
  output logic              halt
);

  rv_core_pkg::stage_e stage;
  rv_core_pkg::stage_e stage_next;

  always_comb begin
    stage_next = stage;
    case (stage)
      rv_core_pkg::st_fetch: stage_next = rv_core_pkg::st_execute;
      rv_core_pkg::st_execute: begin
        if (stop) begin
          stage_next = rv_core_pkg::st_halted;     // ebreak or illegal
        end else if (mem_op) begin
          stage_next = rv_core_pkg::st_memory;
        end else begin
          stage_next = rv_core_pkg::st_writeback;
        end
      end
      rv_core_pkg::st_memory: begin
        if (mem_done) stage_next = rv_core_pkg::st_writeback;
      end
      rv_core_pkg::st_writeback: stage_next = rv_core_pkg::st_fetch;
      default: stage_next = stage;                  // halted stays put
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      stage     <= rv_core_pkg::st_fetch;
      pc        <= RESET_PC;
      mem_start <= 1'b0;
    end else begin
      stage     <= stage_next;
      mem_start <= ex_en && mem_op && !stop;      // high in first memory cycle only
      if (wb_en) pc <= next_pc;
    end
  end

  // instruction register, loaded once per instruction
  always_ff @(posedge clk) begin
    if (stage == rv_core_pkg::st_fetch) inst_q <= inst;
  end

  assign ex_en = (stage == rv_core_pkg::st_execute);
  assign wb_en = (stage == rv_core_pkg::st_writeback);
  assign halt  = (stage == rv_core_pkg::st_halted);

  // stage enables never overlap
  assert property (@(posedge clk) disable iff (reset)
    $onehot0({ex_en, mem_start, wb_en}));

endmodule

/* sources.f */
+incdir+test
rtl/rv_isa_pkg.sv
rtl/rv_core_pkg.sv
rtl/rv_sequencer.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_lsu_apb.sv
rtl/rv_regfile_wb.sv
rtl/rv_core_top.sv
test/tb_rv_core.sv

/* test/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// what a row expects from the core while its instruction runs
typedef enum logic [2:0] {
  kind_none,    // no memory access, pc just moves on
  kind_write,
  kind_read,
  kind_skip,    // jumped over, never executed
  kind_halt
} kind_e;

typedef struct packed {
  rv_isa_pkg::word_t inst;
  kind_e             kind;
  rv_isa_pkg::word_t addr;   // paddr
  rv_isa_pkg::word_t data;   // pwdata, compared under the strobes
  rv_isa_pkg::strb_t strb;
} row_t;

localparam logic [6:0] op_load  = 7'b000_0011;
localparam logic [6:0] op_imm   = 7'b001_0011;
localparam logic [6:0] op_auipc = 7'b001_0111;
localparam logic [6:0] op_store = 7'b010_0011;
localparam logic [6:0] op_lui   = 7'b011_0111;
localparam logic [6:0] op_jalr  = 7'b110_0111;
localparam logic [6:0] op_jal   = 7'b110_1111;
localparam rv_isa_pkg::word_t ebreak_word = 32'h0010_0073;
localparam rv_isa_pkg::word_t data_base   = 32'h0000_2000;

row_t program_rows[$];

function automatic rv_isa_pkg::word_t itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                                 input logic [2:0] f3, input logic [4:0] rd,
                                                 input logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic rv_isa_pkg::word_t stype_word(input logic [11:0] imm, input logic [4:0] rs2,
                                                 input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
endfunction

function automatic rv_isa_pkg::word_t utype_word(input logic [19:0] imm, input logic [4:0] rd,
                                                 input logic [6:0] opc);
  return {imm, rd, opc};
endfunction

function automatic rv_isa_pkg::word_t jtype_word(input logic [20:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
endfunction

task automatic add_row(input rv_isa_pkg::word_t inst, input kind_e kind,
                       input rv_isa_pkg::word_t addr, input rv_isa_pkg::word_t data,
                       input rv_isa_pkg::strb_t strb);
  row_t row;
  row.inst = inst;
  row.kind = kind;
  row.addr = addr;
  row.data = data;
  row.strb = strb;
  program_rows.push_back(row);
endtask

// row n sits at 0x8000_0000 + 4n; x1 holds the data base throughout
task automatic build_program();
  add_row(utype_word(20'h00002, 5'd1, op_lui), kind_none, '0, '0, 4'h0);
  add_row(utype_word(20'h12345, 5'd2, op_lui), kind_none, '0, '0, 4'h0);
  add_row(itype_word(12'h678, 5'd2, 3'b000, 5'd2, op_imm), kind_none, '0, '0, 4'h0);
  add_row(stype_word(12'h000, 5'd2, 5'd1, 3'b010), kind_write, 32'h0000_2000, 32'h1234_5678, 4'hf);
  add_row(itype_word(12'hfff, 5'd0, 3'b000, 5'd3, op_imm), kind_none, '0, '0, 4'h0);
  add_row(itype_word(12'h800, 5'd3, 3'b000, 5'd3, op_imm), kind_none, '0, '0, 4'h0);  // -1 - 2048
  add_row(stype_word(12'h004, 5'd3, 5'd1, 3'b010), kind_write, 32'h0000_2004, 32'hffff_f7ff, 4'hf);
  add_row(utype_word(20'h00001, 5'd4, op_auipc), kind_none, '0, '0, 4'h0);           // pc 0x1c
  add_row(stype_word(12'h008, 5'd4, 5'd1, 3'b010), kind_write, 32'h0000_2008, 32'h8000_101c, 4'hf);
  add_row(itype_word(12'h020, 5'd1, 3'b000, 5'd5, op_imm), kind_none, '0, '0, 4'h0);
  add_row(stype_word(12'hffc, 5'd2, 5'd5, 3'b010), kind_write, 32'h0000_201c, 32'h1234_5678, 4'hf);
  // byte and half lanes
  add_row(stype_word(12'h010, 5'd2, 5'd1, 3'b000), kind_write, 32'h0000_2010, 32'h0000_0078, 4'h1);
  add_row(stype_word(12'h011, 5'd2, 5'd1, 3'b000), kind_write, 32'h0000_2010, 32'h0000_7800, 4'h2);
  add_row(stype_word(12'h012, 5'd2, 5'd1, 3'b000), kind_write, 32'h0000_2010, 32'h0078_0000, 4'h4);
  add_row(stype_word(12'h013, 5'd2, 5'd1, 3'b000), kind_write, 32'h0000_2010, 32'h7800_0000, 4'h8);
  add_row(stype_word(12'h014, 5'd2, 5'd1, 3'b001), kind_write, 32'h0000_2014, 32'h0000_5678, 4'h3);
  add_row(stype_word(12'h016, 5'd2, 5'd1, 3'b001), kind_write, 32'h0000_2014, 32'h5678_0000, 4'hc);
  // loads from 0x2040, filled with 0xaf7c_e6a5
  add_row(itype_word(12'h040, 5'd1, 3'b000, 5'd6, op_load), kind_read, 32'h0000_2040, '0, 4'h0);
  add_row(stype_word(12'h020, 5'd6, 5'd1, 3'b010), kind_write, 32'h0000_2020, 32'hffff_ffa5, 4'hf);
  add_row(itype_word(12'h042, 5'd1, 3'b000, 5'd6, op_load), kind_read, 32'h0000_2040, '0, 4'h0);
  add_row(stype_word(12'h024, 5'd6, 5'd1, 3'b010), kind_write, 32'h0000_2024, 32'h0000_007c, 4'hf);
  add_row(itype_word(12'h043, 5'd1, 3'b100, 5'd6, op_load), kind_read, 32'h0000_2040, '0, 4'h0);
  add_row(stype_word(12'h028, 5'd6, 5'd1, 3'b010), kind_write, 32'h0000_2028, 32'h0000_00af, 4'hf);
  add_row(itype_word(12'h040, 5'd1, 3'b001, 5'd6, op_load), kind_read, 32'h0000_2040, '0, 4'h0);
  add_row(stype_word(12'h02c, 5'd6, 5'd1, 3'b010), kind_write, 32'h0000_202c, 32'hffff_e6a5, 4'hf);
  add_row(itype_word(12'h042, 5'd1, 3'b101, 5'd6, op_load), kind_read, 32'h0000_2040, '0, 4'h0);
  add_row(stype_word(12'h030, 5'd6, 5'd1, 3'b010), kind_write, 32'h0000_2030, 32'h0000_af7c, 4'hf);
  add_row(itype_word(12'h040, 5'd1, 3'b010, 5'd6, op_load), kind_read, 32'h0000_2040, '0, 4'h0);
  add_row(stype_word(12'h034, 5'd6, 5'd1, 3'b010), kind_write, 32'h0000_2034, 32'haf7c_e6a5, 4'hf);
  // jal at 0x74 skips one word, jalr at 0x84 lands on 0x90
  add_row(jtype_word(21'h000008, 5'd7), kind_none, '0, '0, 4'h0);
  add_row(ebreak_word, kind_skip, '0, '0, 4'h0);
  add_row(stype_word(12'h038, 5'd7, 5'd1, 3'b010), kind_write, 32'h0000_2038, 32'h8000_0078, 4'hf);
  add_row(utype_word(20'h00000, 5'd8, op_auipc), kind_none, '0, '0, 4'h0);
  add_row(itype_word(12'h011, 5'd8, 3'b000, 5'd9, op_jalr), kind_none, '0, '0, 4'h0);  // odd target
  add_row(ebreak_word, kind_skip, '0, '0, 4'h0);
  add_row(ebreak_word, kind_skip, '0, '0, 4'h0);
  add_row(stype_word(12'h03c, 5'd9, 5'd1, 3'b010), kind_write, 32'h0000_203c, 32'h8000_0088, 4'hf);
  add_row(ebreak_word, kind_halt, '0, '0, 4'h0);
endtask

`endif

/* test/tb_rv_core.sv */
`timescale 1ns/100ps

module tb_rv_core;

  `include "tb_program.svh"

  localparam rv_isa_pkg::word_t reset_pc = 32'h8000_0000;

  logic              clk = 1'b0;
  logic              reset = 1'b1;
  logic              pready = 1'b0;
  rv_isa_pkg::word_t prdata = '0;
  rv_isa_pkg::word_t inst;
  rv_isa_pkg::word_t pc;
  rv_isa_pkg::word_t paddr;
  rv_isa_pkg::word_t pwdata;
  rv_isa_pkg::strb_t pstrb;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic              halt;

  rv_isa_pkg::word_t rom [64];
  rv_isa_pkg::word_t mem [64];
  logic [5:0]        idx;
  int                wait_left;
  bit                table_ready = 1'b0;
  logic              sel_before = 1'b0;

  // last completed APB transfer
  int                xfer_count = 0;
  logic              seen_write;
  rv_isa_pkg::word_t seen_addr;
  rv_isa_pkg::word_t seen_wdata;
  rv_isa_pkg::strb_t seen_strb;

  rv_core_top #(.RESET_PC(reset_pc)) DUT (
    .clk, .reset, .pc, .inst, .paddr, .psel, .penable, .pwrite, .pwdata, .pstrb,
    .prdata, .pready, .halt
  );

  always #10 clk = ~clk;

  // anything outside the program area reads as an illegal zero word
  assign inst = (pc[31:8] == reset_pc[31:8]) ? rom[pc[7:2]] : 32'h0;

  // every address bit takes part
  function automatic rv_isa_pkg::word_t fill_word(input rv_isa_pkg::word_t a);
    return {a[15:0], a[31:16]} ^ 32'h8f3c_e6a5;
  endfunction

  function automatic rv_isa_pkg::word_t lane_mask(input rv_isa_pkg::strb_t strb);
    return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
  endfunction

  task automatic stop_on_error();
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input rv_isa_pkg::word_t actual,
                            input rv_isa_pkg::word_t expected);
    if (actual !== expected) begin
      $display("mismatch %s: got %h, expected %h", name, actual, expected);
      stop_on_error();
    end
  endtask

  task automatic check_strb(input string name, input rv_isa_pkg::strb_t actual,
                            input rv_isa_pkg::strb_t expected);
    if (actual !== expected) begin
      $display("mismatch %s: got %h, expected %h", name, actual, expected);
      stop_on_error();
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("mismatch %s: got %h, expected %h", name, actual, expected);
      stop_on_error();
    end
  endtask

  // APB slave with 0 to 3 wait cycles per transfer and memory refill in reset
  always @(negedge clk) begin
    if (reset) begin
      for (int w = 0; w < 64; w++) mem[w] = fill_word(data_base + 32'(w) * 32'd4);
      pready <= 1'b0;
    end else if (!psel) begin
      pready <= 1'b0;
    end else if (!penable) begin
      wait_left = $urandom_range(3, 0);                // setup cycle
    end else if (wait_left > 0) begin
      wait_left = wait_left - 1;
    end else if (paddr[31:8] != data_base[31:8]) begin
      $display("APB access at %h is outside the data memory", paddr);
      stop_on_error();
    end else begin
      idx = paddr[7:2];
      if (pwrite) begin
        for (int b = 0; b < 4; b++) begin
          if (pstrb[b]) mem[idx][8*b +: 8] = pwdata[8*b +: 8];
        end
      end else begin
        prdata <= mem[idx];
      end
      pready     <= 1'b1;
      seen_write = pwrite;
      seen_addr  = paddr;
      seen_wdata = pwdata;
      seen_strb  = pstrb;
      xfer_count = xfer_count + 1;
    end
  end

  // penable trails psel by one cycle in every transfer
  always @(negedge clk) begin
    if (!reset) check_flag("penable", penable, psel && sel_before);
    sel_before = psel;
  end

  task automatic wait_for_next_pc(input rv_isa_pkg::word_t row_pc);
    do @(negedge clk); while (pc == row_pc);
  endtask

  task automatic check_transfer(input row_t row);
    check_flag("pwrite", seen_write, row.kind == kind_write);
    check_word("paddr", seen_addr, row.addr);
    check_strb("pstrb", seen_strb, row.strb);
    if (row.kind == kind_write) begin
      check_word("pwdata", seen_wdata & lane_mask(row.strb), row.data & lane_mask(row.strb));
    end
  endtask

  // after ebreak nothing moves for good
  task automatic check_halted(input rv_isa_pkg::word_t row_pc);
    while (!halt) @(negedge clk);
    repeat (20) begin
      @(negedge clk);
      check_word("pc", pc, row_pc);
      check_flag("psel", psel, 1'b0);
      check_flag("halt", halt, 1'b1);
    end
  endtask

  initial begin
    row_t              row;
    rv_isa_pkg::word_t row_pc;
    int                i;
    int                mem_rows;
    void'($urandom(73322));
    build_program();
    for (int r = 0; r < 64; r++) rom[r] = 32'h0;
    foreach (program_rows[r]) rom[r] = program_rows[r].inst;
    table_ready = 1'b1;
    repeat (16) @(posedge clk);
    @(negedge clk);
    check_word("pc", pc, reset_pc);
    check_flag("psel", psel, 1'b0);
    check_flag("halt", halt, 1'b0);
    reset = 1'b0;
    mem_rows = 0;
    for (i = 0; i < program_rows.size(); i++) begin
      row = program_rows[i];
      if (row.kind != kind_skip) begin
        row_pc = reset_pc + 32'(i) * 32'd4;
        check_word("pc", pc, row_pc);
        case (row.kind)
          kind_write, kind_read: begin
            while (xfer_count == mem_rows) @(posedge clk);
            mem_rows = mem_rows + 1;
            check_transfer(row);
            wait_for_next_pc(row_pc);
          end
          kind_halt: check_halted(row_pc);
          default:   wait_for_next_pc(row_pc);
        endcase
        if (xfer_count != mem_rows) begin
          $display("APB transfer seen while row %0d should make no memory access", i);
          stop_on_error();
        end
      end
    end
    $display("No errors");
    $finish;
  end

  // twice the worst case of 8 cycles a row plus reset and the halt tail
  initial begin
    int limit;
    wait (table_ready);
    limit = (program_rows.size() * 8 + 16 + 20) * 2;
    repeat (limit) @(posedge clk);
    $display("timeout: the program did not finish within %0d cycles", limit);
    stop_on_error();
  end

endmodule
